// File: host_pkg.sv
/* Host memory interface definitions */
`default_nettype none

package host_pkg;

	// Line and address widths
	localparam int ADDR_W = 58;
	localparam int LINE_W = 512;

	typedef logic [LINE_W-1:0] line_t;
	typedef logic [ADDR_W-1:0] addr_t;

	// Line offsets from the source pointer
	localparam addr_t HAND_OFFSET  = addr_t'(50331648 + 16384 - 1);
	localparam addr_t INPUT_OFFSET = HAND_OFFSET + addr_t'(1);

	// Handshake line fields
	localparam int TAG0_BIT = 480;
	localparam int TAG1_BIT = 482;
	localparam int BATCH_LO = 448;
	localparam int BATCH_W  = 10;

	// Completion code in the upper 32 bits of the done word
	localparam logic [31:0] DONE_CODE = 32'd16;

endpackage

`default_nettype wire

// File: batch_pkg.sv
/* Batch controller definitions */
`default_nettype none

package batch_pkg;

	// Each batch entry is fetched as this many lines
	localparam int LINES_PER_READ = 4;

	// Local read store
	localparam int BUF_DEPTH = 512;
	localparam int BUF_AW    = $clog2(BUF_DEPTH);
	localparam int PTR_W     = 12;

	typedef logic [PTR_W-1:0]             line_cnt_t;
	typedef logic [host_pkg::BATCH_W-1:0] batch_t;

	typedef enum logic [2:0] {
		IDLE,
		POLL,
		CHECK,
		LOAD,
		STREAM,
		OUTPUT,
		FENCE,
		DONE
	} state_t;

	// Kernel output buffering
	localparam int OUT_FIFO_DEPTH = 16;

endpackage

`default_nettype wire

// File: line_fifo.sv
/* Cache line FIFO */
`timescale 1ns/1ps
`default_nettype none

module line_fifo #(
	parameter int DEPTH = 16
) (
	input  wire                  CLK_400M,
	input  wire                  PresetEmpty,
	input  wire                  clear,
	input  wire                  in_valid,
	input  wire host_pkg::line_t in_data,
	input  wire                  in_last,
	output logic                 in_ready,
	output logic                 out_valid,
	output host_pkg::line_t      out_data,
	output logic                 out_last,
	input  wire                  out_ready
);
	import host_pkg::*;

	localparam int AW = $clog2(DEPTH);

	// Line plus its end-of-batch marker
	logic [LINE_W:0] mem [DEPTH];
	logic [AW-1:0]   wr_ptr;
	logic [AW-1:0]   rd_ptr;
	logic [AW:0]     count;
	logic            push;
	logic            pop;

	// Held closed while cleared so nothing is taken outside a batch
	assign in_ready  = !clear && (count != (AW+1)'(DEPTH));
	assign out_valid = !clear && (count != '0);
	assign push      = in_valid && in_ready;
	assign pop       = out_valid && out_ready;

	assign {out_last, out_data} = mem[rd_ptr];

	always_ff @(posedge CLK_400M) begin
		if (push)
			mem[wr_ptr] <= {in_last, in_data};
	end

	always_ff @(posedge CLK_400M or posedge PresetEmpty) begin
		if (PresetEmpty) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1;
			if (pop)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1;
			if (push && !pop)
				count <= count + 1;
			else if (pop && !push)
				count <= count - 1;
		end
	end

endmodule

`default_nettype wire

// File: read_buffer.sv
/* Batch read line store */
`timescale 1ns/1ps
`default_nettype none

module read_buffer (
	input  wire                       CLK_400M,
	input  wire                       PresetEmpty,
	input  wire                       fill_en,
	input  wire                       rx_valid,
	input  wire host_pkg::line_t      rx_data,
	input  wire                       stream_en,
	input  wire                       load_ready,
	input  wire batch_pkg::line_cnt_t line_total,
	output logic                      filled,
	output logic                      load_valid,
	output host_pkg::line_t           load_data,
	output logic                      streamed
);
	import host_pkg::*;
	import batch_pkg::*;

	line_t     mem [BUF_DEPTH];
	line_cnt_t wr_ptr;
	line_cnt_t wr_idx;
	line_cnt_t rd_ptr;
	line_cnt_t sent_cnt;
	logic      fill_q;
	logic      fill_rise;
	logic      fetch;

	// A new batch starts on the first LOAD cycle
	assign fill_rise = fill_en && !fill_q;
	assign wr_idx    = fill_rise ? '0 : wr_ptr;
	assign filled    = fill_en && !fill_rise && (wr_ptr == line_total);
	assign streamed  = stream_en && (sent_cnt == line_total);

	// Refill the output register when empty or being taken
	assign fetch = stream_en && (rd_ptr != line_total) && (!load_valid || load_ready);

	always_ff @(posedge CLK_400M) begin
		if (fill_en && rx_valid)
			mem[wr_idx[BUF_AW-1:0]] <= rx_data;
		if (fetch)
			load_data <= mem[rd_ptr[BUF_AW-1:0]];
	end

	always_ff @(posedge CLK_400M or posedge PresetEmpty) begin
		if (PresetEmpty) begin
			fill_q     <= 1'b0;
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			sent_cnt   <= '0;
			load_valid <= 1'b0;
		end else begin
			fill_q <= fill_en;
			if (fill_en && rx_valid)
				wr_ptr <= wr_idx + 1;
			else if (fill_rise)
				wr_ptr <= '0;
			if (fill_rise) begin
				rd_ptr   <= '0;
				sent_cnt <= '0;
			end else begin
				if (fetch)
					rd_ptr <= rd_ptr + 1;
				if (load_valid && load_ready)
					sent_cnt <= sent_cnt + 1;
			end
			if (fetch)
				load_valid <= 1'b1;
			else if (load_ready)
				load_valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: batch_ctrl.sv
/* Batch sequencing FSM */
`timescale 1ns/1ps
`default_nettype none

module batch_ctrl (
	input  wire                  CLK_400M,
	input  wire                  PresetEmpty,
	input  wire                  core_start,
	input  wire                  rd_almostfull,
	input  wire                  rx_valid,
	input  wire host_pkg::line_t rx_data,
	input  wire host_pkg::addr_t src_ptr,
	input  wire                  filled,
	input  wire                  streamed,
	input  wire                  last_written,
	input  wire                  op_done,
	output logic                 rd_valid,
	output host_pkg::addr_t      rd_addr,
	output host_pkg::addr_t      hand_addr,
	output batch_pkg::line_cnt_t line_total,
	output logic                 fill_en,
	output logic                 stream_en,
	output logic                 fifo_clear,
	output logic                 data_go,
	output logic                 fence_go,
	output logic                 done_go
);
	import host_pkg::*;
	import batch_pkg::*;

	state_t    state;
	logic      parity;
	logic      tag_seen;
	batch_t    batch_size;
	line_cnt_t req_cnt;
	addr_t     load_addr;

	// ==================================================
	// Handshake line decode
	// ==================================================
	assign hand_addr  = src_ptr + HAND_OFFSET;
	assign load_addr  = src_ptr + INPUT_OFFSET + addr_t'(req_cnt);
	assign batch_size = rx_data[BATCH_LO +: BATCH_W];
	// Even batches wait on tag 0, odd ones on tag 1
	assign tag_seen   = parity ? rx_data[TAG1_BIT] : rx_data[TAG0_BIT];

	assign fill_en    = (state == LOAD);
	assign stream_en  = (state == STREAM);
	assign fifo_clear = !((state == STREAM) || (state == OUTPUT));

	// Read address follows the request that goes out with it
	always_ff @(posedge CLK_400M) begin
		rd_addr <= (state == POLL) ? hand_addr : load_addr;
	end

	// ==================================================
	// State sequence
	// ==================================================
	always_ff @(posedge CLK_400M or posedge PresetEmpty) begin
		if (PresetEmpty) begin
			state      <= IDLE;
			parity     <= 1'b0;
			req_cnt    <= '0;
			line_total <= '0;
			rd_valid   <= 1'b0;
			data_go    <= 1'b0;
			fence_go   <= 1'b0;
			done_go    <= 1'b0;
		end else begin
			rd_valid <= 1'b0;
			data_go  <= 1'b0;
			fence_go <= 1'b0;
			done_go  <= 1'b0;
			case (state)
				IDLE: begin
					if (core_start) begin
						parity <= 1'b0;
						state  <= POLL;
					end
				end
				POLL: begin
					if (!rd_almostfull) begin
						rd_valid <= 1'b1;
						state    <= CHECK;
					end
				end
				CHECK: begin
					if (rx_valid) begin
						if (tag_seen) begin
							line_total <= line_cnt_t'(batch_size) * line_cnt_t'(LINES_PER_READ);
							req_cnt    <= '0;
							parity     <= !parity;
							state      <= LOAD;
						end else begin
							state <= POLL;
						end
					end
				end
				LOAD: begin
					if (!rd_almostfull && (req_cnt != line_total)) begin
						rd_valid <= 1'b1;
						req_cnt  <= req_cnt + 1;
					end
					// All responses stored means all requests went out
					if (filled)
						state <= STREAM;
				end
				STREAM: begin
					if (streamed) begin
						data_go <= 1'b1;
						state   <= OUTPUT;
					end
				end
				OUTPUT: begin
					if (last_written) begin
						fence_go <= 1'b1;
						state    <= FENCE;
					end
				end
				FENCE: begin
					if (op_done) begin
						done_go <= 1'b1;
						state   <= DONE;
					end
				end
				DONE: begin
					if (op_done)
						state <= POLL;
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: wr_issue.sv
/* Host write request generator */
`timescale 1ns/1ps
`default_nettype none

module wr_issue (
	input  wire                  CLK_400M,
	input  wire                  PresetEmpty,
	input  wire                  wr_almostfull,
	input  wire host_pkg::addr_t dst_base,
	input  wire host_pkg::addr_t hand_addr,
	input  wire                  data_go,
	input  wire                  fence_go,
	input  wire                  done_go,
	input  wire                  line_valid,
	input  wire host_pkg::line_t line_data,
	output logic                 line_pop,
	output logic                 wr_valid,
	output logic                 fence_valid,
	output host_pkg::addr_t      wr_addr,
	output host_pkg::line_t      wr_data,
	output logic                 op_done
);
	import host_pkg::*;

	logic  data_mode;
	logic  fence_pend;
	logic  done_pend;
	addr_t out_addr;

	// Fence and done word take priority over data lines
	assign line_pop = data_mode && line_valid && !wr_almostfull && !fence_pend && !done_pend;

	// ==================================================
	// Write payload and running address
	// ==================================================
	always_ff @(posedge CLK_400M) begin
		if (data_go)
			out_addr <= dst_base;
		else if (line_pop)
			out_addr <= out_addr + 1;
		if (!wr_almostfull) begin
			if (fence_pend) begin
				wr_addr <= out_addr;
			end else if (done_pend) begin
				wr_addr <= hand_addr;
				wr_data <= {DONE_CODE, {(LINE_W-32){1'b0}}};
			end else if (line_pop) begin
				wr_addr <= out_addr;
				wr_data <= line_data;
			end
		end
	end

	// ==================================================
	// Request pulses
	// ==================================================
	always_ff @(posedge CLK_400M or posedge PresetEmpty) begin
		if (PresetEmpty) begin
			data_mode   <= 1'b0;
			fence_pend  <= 1'b0;
			done_pend   <= 1'b0;
			wr_valid    <= 1'b0;
			fence_valid <= 1'b0;
			op_done     <= 1'b0;
		end else begin
			wr_valid    <= 1'b0;
			fence_valid <= 1'b0;
			op_done     <= 1'b0;
			if (data_go)
				data_mode <= 1'b1;
			if (fence_go) begin
				data_mode  <= 1'b0;
				fence_pend <= 1'b1;
			end
			if (done_go)
				done_pend <= 1'b1;
			if (!wr_almostfull) begin
				if (fence_pend) begin
					wr_valid    <= 1'b1;
					fence_valid <= 1'b1;
					fence_pend  <= 1'b0;
					op_done     <= 1'b1;
				end else if (done_pend) begin
					wr_valid  <= 1'b1;
					done_pend <= 1'b0;
					op_done   <= 1'b1;
				end else if (line_pop) begin
					wr_valid <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: afu_core.sv
/* Accelerator core top */
`timescale 1ns/1ps
`default_nettype none

module afu_core (
	input  wire                  CLK_400M,
	input  wire                  PresetEmpty,
	input  wire                  core_start,
	input  wire host_pkg::addr_t src_ptr,
	input  wire host_pkg::addr_t dst_ptr,
	// Host read path
	input  wire                  rd_almostfull,
	output logic                 rd_valid,
	output host_pkg::addr_t      rd_addr,
	input  wire                  rx_valid,
	input  wire host_pkg::line_t rx_data,
	// Host write path
	input  wire                  wr_almostfull,
	output logic                 wr_valid,
	output logic                 fence_valid,
	output host_pkg::addr_t      wr_addr,
	output host_pkg::line_t      wr_data,
	// Kernel ports
	output logic                 load_valid,
	output host_pkg::line_t      load_data,
	input  wire                  load_ready,
	input  wire                  out_valid,
	input  wire host_pkg::line_t out_data,
	input  wire                  out_last,
	output logic                 out_ready
);
	import host_pkg::*;
	import batch_pkg::*;

	addr_t     hand_addr;
	line_cnt_t line_total;
	logic      fill_en;
	logic      stream_en;
	logic      fifo_clear;
	logic      data_go;
	logic      fence_go;
	logic      done_go;
	logic      filled;
	logic      streamed;
	logic      last_written;
	logic      op_done;
	logic      fifo_valid;
	line_t     fifo_data;
	logic      fifo_last;
	logic      line_pop;

	// End of batch is seen as the marked line leaves the FIFO
	assign last_written = line_pop && fifo_last;

	// ==================================================
	// Control and read side
	// ==================================================
	batch_ctrl u_ctrl (
		.CLK_400M     (CLK_400M),
		.PresetEmpty  (PresetEmpty),
		.core_start   (core_start),
		.rd_almostfull(rd_almostfull),
		.rx_valid     (rx_valid),
		.rx_data      (rx_data),
		.src_ptr      (src_ptr),
		.filled       (filled),
		.streamed     (streamed),
		.last_written (last_written),
		.op_done      (op_done),
		.rd_valid     (rd_valid),
		.rd_addr      (rd_addr),
		.hand_addr    (hand_addr),
		.line_total   (line_total),
		.fill_en      (fill_en),
		.stream_en    (stream_en),
		.fifo_clear   (fifo_clear),
		.data_go      (data_go),
		.fence_go     (fence_go),
		.done_go      (done_go)
	);

	read_buffer u_rbuf (
		.CLK_400M   (CLK_400M),
		.PresetEmpty(PresetEmpty),
		.fill_en    (fill_en),
		.rx_valid   (rx_valid),
		.rx_data    (rx_data),
		.stream_en  (stream_en),
		.load_ready (load_ready),
		.line_total (line_total),
		.filled     (filled),
		.load_valid (load_valid),
		.load_data  (load_data),
		.streamed   (streamed)
	);

	// ==================================================
	// Kernel output and write side
	// ==================================================
	line_fifo #(
		.DEPTH(OUT_FIFO_DEPTH)
	) u_out_fifo (
		.CLK_400M   (CLK_400M),
		.PresetEmpty(PresetEmpty),
		.clear      (fifo_clear),
		.in_valid   (out_valid),
		.in_data    (out_data),
		.in_last    (out_last),
		.in_ready   (out_ready),
		.out_valid  (fifo_valid),
		.out_data   (fifo_data),
		.out_last   (fifo_last),
		.out_ready  (line_pop)
	);

	wr_issue u_wr (
		.CLK_400M     (CLK_400M),
		.PresetEmpty  (PresetEmpty),
		.wr_almostfull(wr_almostfull),
		.dst_base     (dst_ptr),
		.hand_addr    (hand_addr),
		.data_go      (data_go),
		.fence_go     (fence_go),
		.done_go      (done_go),
		.line_valid   (fifo_valid),
		.line_data    (fifo_data),
		.line_pop     (line_pop),
		.wr_valid     (wr_valid),
		.fence_valid  (fence_valid),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.op_done      (op_done)
	);

endmodule

`default_nettype wire

// File: tb_afu_core_assert.sv
/* Host request rule checks */
`timescale 1ns/1ps
`default_nettype none

module tb_afu_core_assert (
	input wire CLK_400M,
	input wire PresetEmpty,
	input wire rd_valid,
	input wire rd_almostfull,
	input wire wr_valid,
	input wire wr_almostfull,
	input wire fence_valid
);

	// Requests only after an edge that saw room
	rd_gate: assert property (@(posedge CLK_400M) disable iff (PresetEmpty)
		rd_valid |-> !$past(rd_almostfull))
		else $error("rd_valid issued after rd_almostfull was sampled high");

	wr_gate: assert property (@(posedge CLK_400M) disable iff (PresetEmpty)
		wr_valid |-> !$past(wr_almostfull))
		else $error("wr_valid issued after wr_almostfull was sampled high");

	// Fence travels on a write request
	fence_on_write: assert property (@(posedge CLK_400M) disable iff (PresetEmpty)
		fence_valid |-> wr_valid)
		else $error("fence_valid seen without wr_valid");

endmodule

bind afu_core tb_afu_core_assert u_assert (
	.CLK_400M     (CLK_400M),
	.PresetEmpty  (PresetEmpty),
	.rd_valid     (rd_valid),
	.rd_almostfull(rd_almostfull),
	.wr_valid     (wr_valid),
	.wr_almostfull(wr_almostfull),
	.fence_valid  (fence_valid)
);

`default_nettype wire

// File: tb_afu_core.sv
/* Accelerator core testbench */
`timescale 1ns/1ps
`default_nettype none

module tb_afu_core;
	import host_pkg::*;
	import batch_pkg::*;

	localparam int NUM_BATCH = 3;
	// Three batches of up to 16 lines take a few hundred cycles even with stalls
	localparam int TIMEOUT_CYCLES = 4000;
	localparam line_t KERNEL_MASK = {16{32'hA5C3_0F96}};
	localparam line_t DONE_WORD   = line_t'(DONE_CODE) << (LINE_W - 32);

	// DUT inputs
	logic  CLK_400M      = 1'b0;
	logic  PresetEmpty   = 1'b1;
	logic  core_start    = 1'b0;
	addr_t src_ptr       = '0;
	addr_t dst_ptr       = '0;
	logic  rd_almostfull = 1'b1;
	logic  rx_valid      = 1'b0;
	line_t rx_data       = '0;
	logic  wr_almostfull = 1'b1;
	logic  load_ready    = 1'b0;
	logic  out_valid     = 1'b0;
	line_t out_data      = '0;
	logic  out_last      = 1'b0;

	// DUT outputs
	logic  rd_valid;
	addr_t rd_addr;
	logic  wr_valid;
	logic  fence_valid;
	addr_t wr_addr;
	line_t wr_data;
	logic  load_valid;
	line_t load_data;
	logic  out_ready;

	// Host, kernel and write-back model state
	int    batch_sz [NUM_BATCH];
	line_t mem_lines [addr_t];
	line_t rsp_data [$];
	int    rsp_due [$];
	line_t load_exp [$];
	line_t kern_data [$];
	bit    kern_last [$];
	line_t wr_exp [$];
	line_t rsp_line;
	line_t exp_line;
	int    cycle = 0;
	int    due;
	int    last_due = 0;
	int    hand_batch = 0;
	int    hand_polls = 0;
	int    loads_left = 0;
	int    load_idx = 0;
	int    kern_batch = 0;
	int    kern_cnt = 0;
	int    wr_batch = 0;
	int    wr_stage = 0;
	int    wr_line = 0;
	bit    awaiting_done = 1'b0;
	int    checks = 0;
	int    errors = 0;
	int    seed_draw;
	int    bi;
	bit    timed_out;
	int    leftover;

	afu_core dut (
		.CLK_400M     (CLK_400M),
		.PresetEmpty  (PresetEmpty),
		.core_start   (core_start),
		.src_ptr      (src_ptr),
		.dst_ptr      (dst_ptr),
		.rd_almostfull(rd_almostfull),
		.rd_valid     (rd_valid),
		.rd_addr      (rd_addr),
		.rx_valid     (rx_valid),
		.rx_data      (rx_data),
		.wr_almostfull(wr_almostfull),
		.wr_valid     (wr_valid),
		.fence_valid  (fence_valid),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.load_valid   (load_valid),
		.load_data    (load_data),
		.load_ready   (load_ready),
		.out_valid    (out_valid),
		.out_data     (out_data),
		.out_last     (out_last),
		.out_ready    (out_ready)
	);

	always #50 CLK_400M = ~CLK_400M;

	task automatic check_value(input string name, input line_t expected, input line_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAILED at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
		end
	endtask

	task automatic report_error(input string what);
		errors++;
		$display("ERROR at %0t: %s", $time, what);
	endtask

	function automatic line_t random_line();
		line_t l;
		int    k;
		for (k = 0; k < LINE_W / 32; k++)
			l[k*32 +: 32] = $urandom;
		return l;
	endfunction

	// Host memory fills unseen lines with random data
	task automatic read_mem(input addr_t addr, output line_t data);
		if (!mem_lines.exists(addr))
			mem_lines[addr] = random_line();
		data = mem_lines[addr];
	endtask

	// Even batches are ready on tag 0, odd ones on tag 1
	function automatic line_t hand_line(input int idx, input int size, input bit ready);
		line_t l;
		int    tag_want;
		int    tag_other;
		l         = random_line();
		tag_want  = (idx % 2 == 0) ? TAG0_BIT : TAG1_BIT;
		tag_other = (idx % 2 == 0) ? TAG1_BIT : TAG0_BIT;
		l[tag_want]  = ready;
		l[tag_other] = !ready;
		l[BATCH_LO +: BATCH_W] = batch_t'(size);
		return l;
	endfunction

	always @(posedge CLK_400M) begin
		cycle         <= cycle + 1;
		rd_almostfull <= ($urandom_range(0, 3) == 0);
		wr_almostfull <= ($urandom_range(0, 3) == 0);
		load_ready    <= ($urandom_range(0, 3) != 0);
		if (!PresetEmpty) begin
			// Kernel output stays closed outside streaming and write-back
			if (!awaiting_done || loads_left > 0 || rsp_due.size() > 0 || wr_stage != 0)
				check_value("out_ready", '0, line_t'(out_ready));

			// ==================================================
			// Host read port
			// ==================================================
			if (rsp_due.size() > 0 && rsp_due[0] <= cycle) begin
				rx_valid <= 1'b1;
				rx_data  <= rsp_data.pop_front();
				rsp_due.delete(0);
			end else begin
				rx_valid <= 1'b0;
			end
			if (rd_valid) begin
				if (loads_left > 0) begin
					check_value("rd_addr", line_t'(src_ptr + INPUT_OFFSET + addr_t'(load_idx)),
						line_t'(rd_addr));
					read_mem(rd_addr, rsp_line);
					read_mem(src_ptr + INPUT_OFFSET + addr_t'(load_idx), exp_line);
					load_exp.push_back(exp_line);
					load_idx++;
					loads_left--;
				end else begin
					check_value("rd_addr", line_t'(src_ptr + HAND_OFFSET), line_t'(rd_addr));
					if (awaiting_done)
						report_error("handshake line polled before the done word was written");
					if (hand_batch >= NUM_BATCH) begin
						// No batch left, so neither tag is set
						rsp_line = random_line();
						rsp_line[TAG0_BIT] = 1'b0;
						rsp_line[TAG1_BIT] = 1'b0;
					end else if (hand_polls == 0) begin
						rsp_line = hand_line(hand_batch, batch_sz[hand_batch], 1'b0);
						hand_polls++;
					end else begin
						rsp_line   = hand_line(hand_batch, batch_sz[hand_batch], 1'b1);
						loads_left = batch_sz[hand_batch] * LINES_PER_READ;
						load_idx   = 0;
						hand_polls = 0;
						hand_batch++;
						awaiting_done = 1'b1;
						// Fresh input lines for every batch
						mem_lines.delete();
					end
				end
				due = cycle + int'($urandom_range(1, 4));
				if (due <= last_due)
					due = last_due + 1;
				last_due = due;
				rsp_data.push_back(rsp_line);
				rsp_due.push_back(due);
			end

			// ==================================================
			// Kernel model
			// ==================================================
			if (load_valid && load_ready) begin
				if (load_exp.size() == 0) begin
					report_error("kernel load transfer with no line fetched for it");
				end else begin
					exp_line = load_exp.pop_front();
					check_value("load_data", exp_line, load_data);
					kern_data.push_back(exp_line ^ KERNEL_MASK);
					wr_exp.push_back(exp_line ^ KERNEL_MASK);
					kern_cnt++;
					if (kern_cnt == batch_sz[kern_batch] * LINES_PER_READ) begin
						kern_last.push_back(1'b1);
						kern_cnt = 0;
						kern_batch++;
					end else begin
						kern_last.push_back(1'b0);
					end
				end
			end
			// Hold the presented line until the FIFO takes it
			if (!out_valid || out_ready) begin
				if (kern_data.size() > 0 && $urandom_range(0, 3) != 0) begin
					out_valid <= 1'b1;
					out_data  <= kern_data.pop_front();
					out_last  <= kern_last.pop_front();
				end else begin
					out_valid <= 1'b0;
				end
			end

			// ==================================================
			// Host write port
			// ==================================================
			if (wr_valid) begin
				if (wr_batch >= NUM_BATCH) begin
					report_error("write request after the last batch completed");
				end else if (wr_stage == 0) begin
					check_value("fence_valid", '0, line_t'(fence_valid));
					if (wr_exp.size() == 0) begin
						report_error("data write with no kernel line to write");
					end else begin
						exp_line = wr_exp.pop_front();
						check_value("wr_addr", line_t'(dst_ptr + addr_t'(wr_line)),
							line_t'(wr_addr));
						check_value("wr_data", exp_line, wr_data);
						wr_line++;
						if (wr_line == batch_sz[wr_batch] * LINES_PER_READ)
							wr_stage = 1;
					end
				end else if (wr_stage == 1) begin
					check_value("fence_valid", line_t'(1'b1), line_t'(fence_valid));
					wr_stage = 2;
				end else begin
					check_value("fence_valid", '0, line_t'(fence_valid));
					check_value("wr_addr", line_t'(src_ptr + HAND_OFFSET), line_t'(wr_addr));
					check_value("wr_data", DONE_WORD, wr_data);
					wr_stage      = 0;
					wr_line       = 0;
					awaiting_done = 1'b0;
					wr_batch++;
				end
			end
		end
	end

	initial begin
		seed_draw = $urandom(20);
		src_ptr   = addr_t'({$urandom, $urandom});
		dst_ptr   = addr_t'({$urandom, $urandom});
		for (bi = 0; bi < NUM_BATCH; bi++)
			batch_sz[bi] = int'($urandom_range(1, 4));
		repeat (5) @(posedge CLK_400M);
		PresetEmpty <= 1'b0;
		@(posedge CLK_400M);
		core_start <= 1'b1;
		@(posedge CLK_400M);
		core_start <= 1'b0;
		while (wr_batch < NUM_BATCH && cycle < TIMEOUT_CYCLES)
			@(negedge CLK_400M);
		timed_out = (cycle >= TIMEOUT_CYCLES);
		if (timed_out)
			$display("Timeout after %0d cycles, %0d of %0d batches finished",
				cycle, wr_batch, NUM_BATCH);
		else
			repeat (20) @(negedge CLK_400M);
		leftover = load_exp.size() + kern_data.size() + wr_exp.size();
		if (leftover != 0)
			$display("%0d lines were fetched but never written back", leftover);
		$display("Checks: %0d, errors: %0d, timeouts: %0d, lines left: %0d",
			checks, errors, timed_out, leftover);
		if (errors == 0 && !timed_out && leftover == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
host_pkg.sv
batch_pkg.sv
line_fifo.sv
read_buffer.sv
batch_ctrl.sv
wr_issue.sv
afu_core.sv
tb_afu_core_assert.sv
tb_afu_core.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench, then judge the run from its log
verilator --binary --timing --assert --top-module tb_afu_core -f list.f -o sim_afu_core || exit 1
./obj_dir/sim_afu_core > sim.log 2>&1 || echo "Simulation exited with a failing status" >> sim.log
cat sim.log
grep -q "Done: errors found" sim.log && exit 1
grep -q "Done: no errors" sim.log || exit 1
